//--- all.f
+incdir+test
common/rv_isa_pkg.sv
common/core_cfg_pkg.sv
fetch/fetch_unit.sv
verilog/inst_queue.sv
execute/decoder.sv
execute/register_file.sv
execute/execute_unit.sv
verilog/core_top.sv
test/core_tb.sv

//--- common/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  import rv_isa_pkg::*;

  // first pc after reset
  localparam logic [xlen-1:0] default_reset_pc = 64'h0000_0000_8000_0000;

  // instruction queue entries
  localparam int default_queue_depth = 4;

  // queue entry layout, {pc, inst}
  // pc in the upper bits, instruction word in the lower bits
  localparam int entry_width = xlen + inst_width;
  localparam int entry_pc_lsb = inst_width;

endpackage

`default_nettype wire

//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // base widths for rv64i
  localparam int xlen = 64;
  localparam int inst_width = 32;
  localparam int reg_id_width = 5;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_system = 7'b1110011;

  // add/addi/sub all share funct3 000
  localparam logic [2:0] funct3_add = 3'b000;

  // funct7 splits add from sub
  localparam logic [6:0] funct7_add = 7'b0000000;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // the only system encoding we accept
  localparam logic [31:0] ebreak_encoding = 32'h0010_0073;

  // alu operations
  // pass_b forwards operand two, used by lui
  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_pass_b
  } alu_op_t;

endpackage

`default_nettype wire

//--- execute/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  logic [rv_isa_pkg::inst_width-1:0]   inst,
  output logic [rv_isa_pkg::reg_id_width-1:0] rd,
  output logic [rv_isa_pkg::reg_id_width-1:0] rs1,
  output logic [rv_isa_pkg::reg_id_width-1:0] rs2,
  output logic [rv_isa_pkg::xlen-1:0]         imm,
  output logic                                use_imm,
  output logic                                use_pc,
  output rv_isa_pkg::alu_op_t                 alu_op,
  output logic                                writes_rd,
  output logic                                is_ebreak,
  output logic                                is_illegal
);

  import rv_isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;

  // fixed field positions
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // i-type, 12 bits sign-extended
  assign imm_i = {{(xlen - 12){inst[31]}}, inst[31:20]};
  // u-type, upper 20 bits, sign from bit 31
  assign imm_u = {{(xlen - 32){inst[31]}}, inst[31:12], 12'b0};

  always_comb begin
    // defaults describe a no-write add
    imm = imm_i;
    use_imm = 1'b0;
    use_pc = 1'b0;
    alu_op = alu_add;
    writes_rd = 1'b0;
    is_ebreak = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      op_imm: begin
        // only addi
        if (funct3 == funct3_add) begin
          use_imm = 1'b1;
          writes_rd = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      op_reg: begin
        if (funct3 == funct3_add && funct7 == funct7_add) begin
          writes_rd = 1'b1;
        end else if (funct3 == funct3_add && funct7 == funct7_sub) begin
          alu_op = alu_sub;
          writes_rd = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      op_lui: begin
        imm = imm_u;
        use_imm = 1'b1;
        alu_op = alu_pass_b;
        writes_rd = 1'b1;
      end
      op_auipc: begin
        // pc + upper immediate
        imm = imm_u;
        use_imm = 1'b1;
        use_pc = 1'b1;
        writes_rd = 1'b1;
      end
      op_system: begin
        // whole word must match, ecall and csr ops are illegal here
        if (inst == ebreak_encoding) begin
          is_ebreak = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- execute/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                issue_valid,
  input  logic [core_cfg_pkg::entry_width-1:0] issue_entry,
  input  logic                                retire_ready,
  output logic                                issue_ready,
  output logic                                retire_valid,
  output logic [rv_isa_pkg::xlen-1:0]         retire_pc,
  output logic [rv_isa_pkg::reg_id_width-1:0] retire_rd,
  output logic                                retire_wen,
  output logic [rv_isa_pkg::xlen-1:0]         retire_wdata,
  output logic                                halted,
  output logic                                halt_illegal
);

  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [xlen-1:0] pc;
  logic [inst_width-1:0] inst;
  logic [reg_id_width-1:0] rd;
  logic [reg_id_width-1:0] rs1;
  logic [reg_id_width-1:0] rs2;
  logic [xlen-1:0] imm;
  logic use_imm;
  logic use_pc;
  alu_op_t alu_op;
  logic writes_rd;
  logic is_ebreak;
  logic is_illegal;
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic [xlen-1:0] operand_1;
  logic [xlen-1:0] operand_2;
  logic [xlen-1:0] result;
  logic retire_fire;

  // unpack {pc, inst}
  assign pc = issue_entry[entry_pc_lsb +: xlen];
  assign inst = issue_entry[inst_width-1:0];

  decoder decoder_i (
    .inst       (inst),
    .rd         (rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .imm        (imm),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .alu_op     (alu_op),
    .writes_rd  (writes_rd),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  // written on the retire edge, next entry sees the new value
  register_file register_file_i (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .wen     (retire_fire && writes_rd),
    .rd      (rd),
    .wdata   (result),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // auipc takes pc, everything else rs1
  assign operand_1 = use_pc ? pc : rdata_1;
  assign operand_2 = use_imm ? imm : rdata_2;

  always_comb begin
    case (alu_op)
      alu_add: result = operand_1 + operand_2;
      alu_sub: result = operand_1 - operand_2;
      default: result = operand_2;
    endcase
  end

  // single-cycle stage, issue and retire are one transfer
  assign issue_ready = retire_ready && !halted;
  assign retire_valid = issue_valid && !halted;
  assign retire_fire = retire_valid && retire_ready;

  assign retire_pc = pc;
  assign retire_rd = rd;
  // ebreak and illegal leave writes_rd low
  assign retire_wen = writes_rd;
  assign retire_wdata = result;

  // sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
      halt_illegal <= 1'b0;
    end else if (retire_fire && (is_ebreak || is_illegal)) begin
      halted <= 1'b1;
      halt_illegal <= is_illegal;
    end
  end

  // once halted, stays halted and nothing else retires
  a_no_retire_halted: assert property (
    @(posedge clk) disable iff (reset) halted |=> halted && !retire_fire
  );

endmodule

`default_nettype wire

//--- execute/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                                clk,
  input  logic [rv_isa_pkg::reg_id_width-1:0] rs1,
  input  logic [rv_isa_pkg::reg_id_width-1:0] rs2,
  input  logic                                wen,
  input  logic [rv_isa_pkg::reg_id_width-1:0] rd,
  input  logic [rv_isa_pkg::xlen-1:0]         wdata,
  output logic [rv_isa_pkg::xlen-1:0]         rdata_1,
  output logic [rv_isa_pkg::xlen-1:0]         rdata_2
);

  import rv_isa_pkg::*;

  localparam int num_regs = 2 ** reg_id_width;

  logic [xlen-1:0] regs [num_regs];

  // x0 reads as zero whatever the array holds
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

  // writes to x0 dropped
  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = core_cfg_pkg::default_reset_pc
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   inst_valid,
  input  logic [rv_isa_pkg::inst_width-1:0]      inst,
  input  logic                                   fetch_ready,
  output logic                                   inst_ready,
  output logic                                   fetch_valid,
  output logic [core_cfg_pkg::entry_width-1:0]   fetch_entry
);

  import rv_isa_pkg::*;

  logic [xlen-1:0] pc;
  logic accept;

  // stage can take a new word when empty or draining this cycle
  assign inst_ready = fetch_ready || !fetch_valid;
  assign accept = inst_valid && inst_ready;

  // pc of the next instruction to be accepted
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (accept) begin
      pc <= pc + xlen'(4);
    end
  end

  // output stage valid
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_valid <= 1'b0;
    end else if (accept) begin
      fetch_valid <= 1'b1;
    end else if (fetch_ready) begin
      fetch_valid <= 1'b0;
    end
  end

  // payload, pc tag on top
  always_ff @(posedge clk) begin
    if (accept) begin
      fetch_entry <= {pc, inst};
    end
  end

  // stalled entry must hold until the queue takes it
  property p_entry_hold;
    @(posedge clk) disable iff (reset)
      fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_entry);
  endproperty
  a_entry_hold: assert property (p_entry_hold);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module core_tb -f all.f -o core_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/core_sim > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass message in the log"; exit 1; }
exit 0

//--- test/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH
`default_nettype none

// architectural state seen by the program
logic [63:0] model_regs [32];
logic [63:0] model_pc;

task automatic model_reset(input logic [63:0] start_pc);
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = 64'd0;
  end
  model_pc = start_pc;
endtask

// retire one word in program order, return what the retire port should show
task automatic model_retire(
  input  logic [31:0] word,
  output logic [63:0] exp_pc,
  output logic [4:0]  exp_rd,
  output logic        exp_wen,
  output logic [63:0] exp_wdata,
  output logic        exp_halt,
  output logic        exp_illegal
);
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [63:0] src_a;
  logic [63:0] src_b;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  opc = word[6:0];
  f3 = word[14:12];
  f7 = word[31:25];
  // x0 entry never written, so it reads as zero
  src_a = model_regs[word[19:15]];
  src_b = model_regs[word[24:20]];
  imm_i = {{52{word[31]}}, word[31:20]};
  imm_u = {{32{word[31]}}, word[31:12], 12'h000};
  exp_pc = model_pc;
  exp_rd = word[11:7];
  exp_wen = 1'b0;
  exp_wdata = 64'd0;
  exp_halt = 1'b0;
  exp_illegal = 1'b0;
  if (opc == op_reg && f3 == 3'b000 && f7 == 7'b0000000) begin
    exp_wen = 1'b1;
    exp_wdata = src_a + src_b;
  end else if (opc == op_reg && f3 == 3'b000 && f7 == funct7_sub) begin
    exp_wen = 1'b1;
    exp_wdata = src_a - src_b;
  end else if (opc == op_imm && f3 == 3'b000) begin
    exp_wen = 1'b1;
    exp_wdata = src_a + imm_i;
  end else if (opc == op_lui) begin
    exp_wen = 1'b1;
    exp_wdata = imm_u;
  end else if (opc == op_auipc) begin
    exp_wen = 1'b1;
    exp_wdata = model_pc + imm_u;
  end else if (word == ebreak_encoding) begin
    exp_halt = 1'b1;
  end else begin
    // anything else stops the core as illegal
    exp_halt = 1'b1;
    exp_illegal = 1'b1;
  end
  if (exp_wen && exp_rd != 5'd0) begin
    model_regs[exp_rd] = exp_wdata;
  end
  model_pc = model_pc + 64'd4;
endtask

`default_nettype wire
`endif

//--- test/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  localparam logic [63:0] start_pc = default_reset_pc;

  logic clk;
  logic reset;
  logic inst_valid;
  logic [31:0] inst;
  logic inst_ready;
  logic retire_ready;
  logic retire_valid;
  logic [63:0] retire_pc;
  logic [4:0] retire_rd;
  logic retire_wen;
  logic [63:0] retire_wdata;
  logic halted;
  logic halt_illegal;

  logic [31:0] prog [$];
  int error_count;
  int test_count;
  int failed_tests;

  `include "rv_ref_model.svh"

  core_top #(
    .reset_pc    (start_pc),
    .queue_depth (default_queue_depth)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_ready   (inst_ready),
    .retire_ready (retire_ready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_wdata (retire_wdata),
    .halted       (halted),
    .halt_illegal (halt_illegal)
  );

  // 100 ns period
  always #50 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    error_count++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic apply_reset;
    @(negedge clk);
    reset = 1'b1;
    inst_valid = 1'b0;
    retire_ready = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    #1;
    if (retire_valid || halted || halt_illegal) begin
      report_error("retire and halt outputs not idle after reset");
    end
  endtask

  function automatic logic [4:0] pick_reg(input int zero_pct);
    if (($urandom % 100) < zero_pct) begin
      return 5'd0;
    end
    return 5'($urandom_range(31, 1));
  endfunction

  // add, sub or addi over random registers
  function automatic logic [31:0] rand_arith(input int zero_pct);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    rd = pick_reg(zero_pct);
    rs1 = pick_reg(zero_pct);
    rs2 = pick_reg(zero_pct);
    imm = 12'($urandom);
    case ($urandom % 3)
      0: return {7'b0000000, rs2, rs1, 3'b000, rd, op_reg};
      1: return {funct7_sub, rs2, rs1, 3'b000, rd, op_reg};
      default: return {imm, rs1, 3'b000, rd, op_imm};
    endcase
  endfunction

  // lui or auipc with a random upper immediate
  function automatic logic [31:0] rand_upper(input int zero_pct);
    logic [4:0] rd;
    logic [19:0] upper;
    rd = pick_reg(zero_pct);
    upper = 20'($urandom);
    if ($urandom % 2 == 0) begin
      return {upper, rd, op_lui};
    end
    return {upper, rd, op_auipc};
  endfunction

  // load every register with a known value, x0 as source only
  task automatic start_program;
    prog.delete();
    for (int r = 1; r < 32; r++) begin
      prog.push_back({12'($urandom), 5'd0, 3'b000, 5'(r), op_imm});
    end
  endtask

  // halt_at marks the halting word, stall_from starts a 16 cycle retire stall
  task automatic run_test(input string name, input int valid_pct, input int ready_pct,
                          input int halt_at, input int stall_from);
    int idx;
    int retired;
    int expect_count;
    int cycles;
    int limit;
    int errs_before;
    logic in_fire;
    logic out_fire;
    logic stall;
    logic halt_due;
    logic ill_due;
    logic halt_seen;
    logic full_seen;
    logic done;
    logic [63:0] e_pc;
    logic [4:0] e_rd;
    logic e_wen;
    logic [63:0] e_wdata;
    logic e_halt;
    logic e_ill;
    errs_before = error_count;
    expect_count = (halt_at >= 0) ? halt_at + 1 : prog.size();
    limit = 40 * prog.size() + 200;
    apply_reset();
    model_reset(start_pc);
    idx = 0;
    retired = 0;
    cycles = 0;
    in_fire = 1'b0;
    out_fire = 1'b0;
    halt_due = 1'b0;
    ill_due = 1'b0;
    halt_seen = 1'b0;
    full_seen = 1'b0;
    done = 1'b0;
    while (!done && cycles < limit) begin
      @(negedge clk);
      cycles++;
      // transfers of the last rising edge
      if (in_fire) begin
        idx++;
      end
      if (halt_due && !halt_seen) begin
        halt_seen = 1'b1;
        if (halted !== 1'b1) report_mismatch("halted", 64'(halted), 64'd1);
        if (halt_illegal !== ill_due) begin
          report_mismatch("halt_illegal", 64'(halt_illegal), 64'(ill_due));
        end
      end
      stall = (stall_from >= 0) && (cycles >= stall_from) && (cycles < stall_from + 16);
      retire_ready = stall ? 1'b0 : (($urandom % 100) < ready_pct);
      // a pending offer stays as it is
      if (!(inst_valid && !in_fire)) begin
        if (idx < prog.size()) begin
          inst_valid = stall || (($urandom % 100) < valid_pct);
          inst = prog[idx];
        end else begin
          inst_valid = 1'b0;
        end
      end
      #1;
      in_fire = inst_valid && inst_ready;
      out_fire = retire_valid && retire_ready;
      if (stall && !inst_ready) begin
        full_seen = 1'b1;
      end
      if (halted && !halt_due) begin
        report_error($sformatf("halted rose before the halting word in %s", name));
      end
      if (halt_seen && retire_valid) begin
        report_error("retire_valid raised after the core halted");
      end
      if (out_fire) begin
        if (retired >= expect_count) begin
          report_error("an instruction retired after the halting one");
        end else begin
          model_retire(prog[retired], e_pc, e_rd, e_wen, e_wdata, e_halt, e_ill);
          if (retire_pc !== e_pc) report_mismatch("retire_pc", retire_pc, e_pc);
          if (retire_wen !== e_wen) report_mismatch("retire_wen", 64'(retire_wen), 64'(e_wen));
          if (e_wen && retire_rd !== e_rd) begin
            report_mismatch("retire_rd", 64'(retire_rd), 64'(e_rd));
          end
          if (e_wen && retire_wdata !== e_wdata) begin
            report_mismatch($sformatf("retire_wdata of word %0d", retired), retire_wdata, e_wdata);
          end
          if (e_halt) begin
            halt_due = 1'b1;
            ill_due = e_ill;
          end
        end
        retired++;
      end
      if (halt_at < 0) begin
        done = (retired == expect_count);
      end else begin
        done = halt_seen && !inst_ready && (retired == expect_count);
      end
    end
    if (!done) begin
      report_error($sformatf("%s did not finish within %0d cycles", name, limit));
    end
    if (stall_from >= 0 && !full_seen) begin
      report_error("inst_ready never dropped while retire_ready was held low");
    end
    inst_valid = 1'b0;
    retire_ready = 1'b0;
    test_count++;
    if (error_count != errs_before) begin
      failed_tests++;
    end
    $display("test %0d %-14s %s, %0d retired", test_count, name,
             (error_count == errs_before) ? "ok" : "with errors", retired);
  endtask

  initial begin
    int halt_at;
    clk = 1'b0;
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = 32'd0;
    retire_ready = 1'b0;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    void'($urandom(32'h5419ea65));

    start_program();
    repeat (200) prog.push_back(rand_arith(3));
    run_test("random_arith", 100, 100, -1, -1);

    // mostly upper immediates, arithmetic mixed in to use them
    start_program();
    repeat (60) prog.push_back((($urandom % 3) != 0) ? rand_upper(3) : rand_arith(3));
    run_test("lui_auipc", 100, 100, -1, -1);

    start_program();
    repeat (100) prog.push_back((($urandom % 5) != 0) ? rand_arith(40) : rand_upper(40));
    run_test("x0_hardwired", 100, 100, -1, -1);

    start_program();
    repeat (150) prog.push_back((($urandom % 4) != 0) ? rand_arith(5) : rand_upper(5));
    run_test("backpressure", 60, 50, -1, 30);

    // words after the halt must never retire
    start_program();
    repeat (40) prog.push_back(rand_arith(3));
    halt_at = prog.size();
    prog.push_back(ebreak_encoding);
    repeat (8) prog.push_back(rand_arith(3));
    run_test("ebreak_halt", 100, 100, halt_at, -1);

    // load opcode is not supported
    start_program();
    repeat (30) prog.push_back(rand_arith(3));
    halt_at = prog.size();
    prog.push_back({25'($urandom), 7'b0000011});
    repeat (8) prog.push_back(rand_arith(3));
    run_test("illegal_inst", 100, 100, halt_at, -1);

    $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = core_cfg_pkg::default_reset_pc,
  parameter int queue_depth = core_cfg_pkg::default_queue_depth
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                inst_valid,
  input  logic [rv_isa_pkg::inst_width-1:0]   inst,
  output logic                                inst_ready,
  input  logic                                retire_ready,
  output logic                                retire_valid,
  output logic [rv_isa_pkg::xlen-1:0]         retire_pc,
  output logic [rv_isa_pkg::reg_id_width-1:0] retire_rd,
  output logic                                retire_wen,
  output logic [rv_isa_pkg::xlen-1:0]         retire_wdata,
  output logic                                halted,
  output logic                                halt_illegal
);

  import core_cfg_pkg::*;

  // fetch -> queue
  logic fetch_valid;
  logic fetch_ready;
  logic [entry_width-1:0] fetch_entry;
  // queue -> execute
  logic issue_valid;
  logic issue_ready;
  logic [entry_width-1:0] issue_entry;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_unit_i (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .fetch_ready (fetch_ready),
    .inst_ready  (inst_ready),
    .fetch_valid (fetch_valid),
    .fetch_entry (fetch_entry)
  );

  inst_queue #(
    .width (entry_width),
    .depth (queue_depth)
  ) inst_queue_i (
    .clk        (clk),
    .reset      (reset),
    .push_valid (fetch_valid),
    .push_data  (fetch_entry),
    .pop_ready  (issue_ready),
    .push_ready (fetch_ready),
    .pop_valid  (issue_valid),
    .pop_data   (issue_entry)
  );

  execute_unit execute_unit_i (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_entry  (issue_entry),
    .retire_ready (retire_ready),
    .issue_ready  (issue_ready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_wdata (retire_wdata),
    .halted       (halted),
    .halt_illegal (halt_illegal)
  );

endmodule

`default_nettype wire

//--- verilog/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
  parameter int width = 96,
  parameter int depth = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push_valid,
  input  logic [width-1:0] push_data,
  input  logic             pop_ready,
  output logic             push_ready,
  output logic             pop_valid,
  output logic [width-1:0] pop_data
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [ptr_width:0] full_count = (ptr_width + 1)'(depth);
  localparam logic [ptr_width-1:0] last_slot = ptr_width'(depth - 1);

  // storage, no reset needed
  logic [width-1:0] mem [depth];
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width:0] count;
  logic push;
  logic pop;

  assign pop_valid = (count != '0);
  assign pop_data = mem[rd_ptr];
  // full queue still takes a push when the head leaves
  assign push_ready = (count != full_count) || pop_ready;

  assign push = push_valid && push_ready;
  assign pop = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset) count <= full_count);

  // pointers only meet on a pop when the queue is full
  a_no_empty_pop: assert property (
    @(posedge clk) disable iff (reset) pop |-> (rd_ptr != wr_ptr) || (count == full_count)
  );

endmodule

`default_nettype wire
